// File: src/barrel_pkg.sv
// Shared definitions for the barrel-scheduled PC front end
// Holds the address and thread widths, the start-address rule and the
// packed structs that travel between the counter, memory and controller
package barrel_pkg;

    // --------------------------------------------------
    // Sizes

    // Width of one instruction address
    localparam int PC_WIDTH = 10;

    // Number of hardware threads in the barrel
    // At least 3 are needed so a write-back lands before the same thread is read again
    localparam int THREAD_COUNT = 8;

    // Width of a thread number
    localparam int THREAD_ADDR_WIDTH = 3;

    // Distance between the start addresses of neighbouring threads
    localparam int THREAD_START_STRIDE = 64;

    typedef logic [PC_WIDTH-1:0]          pc_t;
    typedef logic [THREAD_ADDR_WIDTH-1:0] thread_t;

    // --------------------------------------------------
    // Structs

    // Stored state of one thread
    typedef struct packed {
        pc_t current_pc;   // Next PC in sequence
        pc_t previous_pc;  // PC to issue again if the slot is annulled
    } pc_pair_t;

    // Decision inputs for one issue slot
    typedef struct packed {
        logic io_ready;           // Low means the slot is annulled
        logic jump;               // High means take the branch
        pc_t  branch_destination;
    } issue_ctrl_t;

    // Instruction address leaving the front end
    typedef struct packed {
        logic    valid;
        thread_t thread;
        pc_t     pc;
    } issue_t;

    // Thread t begins execution at t times the stride
    function automatic pc_t start_pc(input int unsigned thread_index);
        return pc_t'(thread_index * THREAD_START_STRIDE);
    endfunction

endpackage

// File: src/thread_counter.sv
// Round-robin thread numbering for the barrel scheduler
// Provides the thread in its issue slot together with the one before and
// the one after it, all straight from flops
`timescale 1ns/1ns

module thread_counter
    import barrel_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    output thread_t current_thread,
    output thread_t next_thread,
    output thread_t previous_thread
);

    // Last valid thread number, used both for wrapping and for the reset value
    localparam thread_t LAST_THREAD = thread_t'(THREAD_COUNT - 1);

    // Step a thread number forward by one and wrap at THREAD_COUNT
    function automatic thread_t wrap_increment(input thread_t thread);
        return (thread == LAST_THREAD) ? thread_t'(0) : thread_t'(thread + 1'b1);
    endfunction

    // --------------------------------------------------
    // Counter

    // All three numbers are kept in their own registers
    // Only next_thread has an adder in front of it, and that adder feeds
    // its own flop rather than the memory address
    always_ff @(posedge clock) begin
        if (reset) begin
            current_thread  <= thread_t'(0);
            next_thread     <= thread_t'(1);
            previous_thread <= LAST_THREAD;
        end else begin
            previous_thread <= current_thread;
            current_thread  <= next_thread;
            next_thread     <= wrap_increment(next_thread);
        end
    end

    // --------------------------------------------------
    // Checks

    // The three registers must stay in lockstep or the memory would be
    // read and written for the wrong threads
    assert property (@(posedge clock) disable iff (reset)
        next_thread == wrap_increment(current_thread))
    else $error("thread_counter: next_thread lost step with current_thread");

endmodule

// File: src/thread_pc_memory.sv
// Per-thread PC storage for the barrel front end
// Keeps the sequential and re-issue PC of every thread with one write
// port, one registered read port and start addresses loaded by reset
`timescale 1ns/1ns

module thread_pc_memory
    import barrel_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     write_enable,
    input  thread_t  write_thread,
    input  pc_pair_t write_pair,
    input  thread_t  read_thread,
    output pc_pair_t read_pair
);

    // One entry per hardware thread
    pc_pair_t pairs [THREAD_COUNT];

    // --------------------------------------------------
    // Storage

    // Reset puts every thread back at its start address with both PCs equal
    // so an annulled first slot simply issues the start address again
    // Outside reset the array behaves as a simple dual-port RAM
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pairs[t] <= '{current_pc: start_pc(t), previous_pc: start_pc(t)};
            end
        end else if (write_enable) begin
            pairs[write_thread] <= write_pair;
        end
    end

    // --------------------------------------------------
    // Read port

    // Data shows up one edge after the address
    // The counter presents next_thread here, so the data lines up with
    // current_thread in the following cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            read_pair <= '0;
        end else begin
            read_pair <= pairs[read_thread];
        end
    end

    // --------------------------------------------------
    // Checks

    // There is no write-to-read forwarding
    // Round-robin spacing keeps the write slot two threads behind the read
    // slot, so both ports must never meet on one entry
    assert property (@(posedge clock) disable iff (reset)
        write_enable |-> (write_thread != read_thread))
    else $error("thread_pc_memory: write and read hit thread %0d together", read_thread);

endmodule

// File: src/pc_controller.sv
// PC selection for one issue slot of the barrel scheduler
// Registers the decision inputs, picks the sequential, branch or re-issue
// PC for the thread in its slot and prepares that thread's write-back
`timescale 1ns/1ns

module pc_controller
    import barrel_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  issue_ctrl_t control,
    input  thread_t     current_thread,
    input  pc_pair_t    read_pair,
    output logic        write_enable,
    output pc_pair_t    write_pair,
    output issue_t      issue
);

    issue_ctrl_t control_synced;
    pc_t         jump_pc;
    pc_t         selected_pc;
    logic        fill_stage;
    logic        issue_valid;
    thread_t     issue_thread;
    pc_t         issue_pc;
    pc_t         writeback_pc;

    // --------------------------------------------------
    // Input register

    // The inputs are plain levels with no handshake
    // One register stage lines them up with the memory read data, which
    // also arrives one edge late
    always_ff @(posedge clock) begin
        if (reset) begin
            control_synced <= '0;
        end else begin
            control_synced <= control;
        end
    end

    // --------------------------------------------------
    // Selection

    // First choose between the branch target and the sequential PC
    always_comb begin
        if (control_synced.jump) begin
            jump_pc = control_synced.branch_destination;
        end else begin
            jump_pc = read_pair.current_pc;
        end
    end

    // An annulled slot overrides any jump and replays the last issued PC
    always_comb begin
        if (control_synced.io_ready) begin
            selected_pc = jump_pc;
        end else begin
            selected_pc = read_pair.previous_pc;
        end
    end

    // --------------------------------------------------
    // Valid fill

    // Two stages after reset release
    // The first stage covers the memory read that is still in flight and
    // the second covers the output register itself
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_stage  <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            fill_stage  <= 1'b1;
            issue_valid <= fill_stage;
        end
    end

    // --------------------------------------------------
    // Output register

    // The issued PC leaves with the number of the thread that owned the slot
    always_ff @(posedge clock) begin
        issue_thread <= current_thread;
        issue_pc     <= selected_pc;
    end

    assign issue = '{valid: issue_valid, thread: issue_thread, pc: issue_pc};

    // --------------------------------------------------
    // Write-back

    // A second copy of the selected PC feeds only the memory
    // This keeps the jump select away from the memory write path and the
    // synthesis tool can still merge the two if timing allows
    always_ff @(posedge clock) begin
        writeback_pc <= selected_pc;
    end

    // Enabled together with issue.valid so no garbage reaches the memory
    // while the pipeline is still filling
    always_ff @(posedge clock) begin
        if (reset) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= fill_stage;
        end
    end

    // The successor wraps at the top of the address range
    // The issued PC itself becomes the value to replay on a later annul
    assign write_pair = '{
        current_pc:  pc_t'(writeback_pc + pc_t'(1)),
        previous_pc: writeback_pc
    };

    // --------------------------------------------------
    // Checks

    // An annulled slot must replay the PC that the same thread issued on
    // its previous slot, which the write-back recorded as previous_pc
    // Only applies once that earlier slot was itself a valid issue
    assert property (@(posedge clock) disable iff (reset)
        (!control_synced.io_ready && $past(issue.valid, THREAD_COUNT - 1))
        |=> (issue.pc == $past(issue.pc, THREAD_COUNT)))
    else $error("pc_controller: annulled slot did not re-issue previous_pc");

endmodule

// File: src/barrel_pc_top.sv
// Program counter front end of a barrel-scheduled multithreaded processor
// Threads issue in strict round-robin order, one per clock, each with its
// own sequential and re-issue PC held in a small memory
`timescale 1ns/1ns

module barrel_pc_top
    import barrel_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  issue_ctrl_t control,
    output issue_t      issue
);

    thread_t  current_thread;
    thread_t  next_thread;
    thread_t  previous_thread;
    pc_pair_t read_pair;
    pc_pair_t write_pair;
    logic     write_enable;

    // --------------------------------------------------
    // Thread scheduling

    thread_counter thread_counter_inst (
        .clock           (clock),
        .reset           (reset),
        .current_thread  (current_thread),
        .next_thread     (next_thread),
        .previous_thread (previous_thread)
    );

    // --------------------------------------------------
    // PC storage

    // Reading one thread ahead makes the registered data belong to the
    // thread in its issue slot
    // Writing one thread behind lets the write-back register settle first
    thread_pc_memory thread_pc_memory_inst (
        .clock        (clock),
        .reset        (reset),
        .write_enable (write_enable),
        .write_thread (previous_thread),
        .write_pair   (write_pair),
        .read_thread  (next_thread),
        .read_pair    (read_pair)
    );

    // --------------------------------------------------
    // Selection and issue

    pc_controller pc_controller_inst (
        .clock          (clock),
        .reset          (reset),
        .control        (control),
        .current_thread (current_thread),
        .read_pair      (read_pair),
        .write_enable   (write_enable),
        .write_pair     (write_pair),
        .issue          (issue)
    );

endmodule

// File: tests/barrel_pc_tb.sv
// Testbench for the barrel-scheduled PC front end
// Drives directed and random issue controls, models every thread's PC pair
// and checks each valid issue against a reference selection function
`timescale 1ns/1ns

module barrel_pc_tb
    import barrel_pkg::*;
();

    // --------------------------------------------------
    // Run length

    localparam int RESET_CYCLES      = 8;
    localparam int START_CYCLES      = 4 * THREAD_COUNT;
    localparam int JUMP_CYCLES       = THREAD_COUNT;
    localparam int WRAP_CYCLES       = 5 * THREAD_COUNT;
    localparam int NOT_READY_CYCLES  = 3 * THREAD_COUNT;
    localparam int RECOVER_CYCLES    = 2 * THREAD_COUNT;
    localparam int RANDOM_CYCLES     = 2000;
    localparam int STIMULUS_CYCLES   = START_CYCLES + JUMP_CYCLES + WRAP_CYCLES
                                     + NOT_READY_CYCLES + RECOVER_CYCLES + RANDOM_CYCLES;
    // Reset, every stimulus cycle and a margin for the pipeline to drain
    localparam int TIMEOUT_CYCLES    = RESET_CYCLES + STIMULUS_CYCLES + 20;

    // Jump target close to the top so the following slots wrap through zero
    localparam pc_t NEAR_TOP_PC = pc_t'((1 << PC_WIDTH) - 3);

    logic        clock;
    logic        reset;
    issue_ctrl_t control;
    issue_t      issue;

    integer      seed;
    int          error_count;
    int          issue_count;
    int          cycle_count;
    int          reset_edges;
    int          edges_after_reset;
    bit          stimulus_done;

    // Controls in flight between the input pins and the issue output
    issue_ctrl_t control_queue [$];

    // Model of the per-thread state
    pc_t         model_current  [THREAD_COUNT];
    pc_t         model_previous [THREAD_COUNT];
    thread_t     expected_thread;

    barrel_pc_top barrel_pc_top_inst (
        .clock   (clock),
        .reset   (reset),
        .control (control),
        .issue   (issue)
    );

    always #2 clock = ~clock;

    // --------------------------------------------------
    // Reference model

    // Annulled slots replay the last PC, else a jump wins over sequence
    function automatic pc_t expected_issue_pc(input pc_t sequential_pc,
                                              input pc_t replay_pc,
                                              input issue_ctrl_t ctrl);
        if (!ctrl.io_ready) begin
            return replay_pc;
        end
        if (ctrl.jump) begin
            return ctrl.branch_destination;
        end
        return sequential_pc;
    endfunction

    // --------------------------------------------------
    // Stimulus tasks

    // One control per cycle, applied on the falling edge and queued for the model
    task automatic drive_control(input logic io_ready, input logic jump, input pc_t destination);
        issue_ctrl_t next_control;
        next_control = '{io_ready: io_ready, jump: jump, branch_destination: destination};
        control = next_control;
        control_queue.push_back(next_control);
        @(negedge clock);
    endtask

    task automatic run_sequential(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_control(1'b1, 1'b0, pc_t'($random(seed)));
        end
    endtask

    task automatic run_jumps(input int cycles, input pc_t destination);
        for (int i = 0; i < cycles; i++) begin
            drive_control(1'b1, 1'b1, destination);
        end
    endtask

    // Every other annulled slot also requests a jump, which must be ignored
    task automatic run_not_ready(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_control(1'b0, i[0], pc_t'($random(seed)));
        end
    endtask

    // Ready about three quarters of the time and jump about one in five
    task automatic run_random(input int cycles);
        logic ready;
        logic jump;
        for (int i = 0; i < cycles; i++) begin
            ready = (($random(seed) & 3) != 0);
            jump  = ($unsigned($random(seed)) % 5) == 0;
            drive_control(ready, jump, pc_t'($random(seed)));
        end
    endtask

    // --------------------------------------------------
    // Main sequence

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        control       = '0;
        seed          = 32'h435a88e3;
        error_count   = 0;
        issue_count   = 0;
        stimulus_done = 1'b0;
        // Each thread starts at its index times the stride, both PCs equal
        for (int t = 0; t < THREAD_COUNT; t++) begin
            model_current[t]  = pc_t'(t * THREAD_START_STRIDE);
            model_previous[t] = pc_t'(t * THREAD_START_STRIDE);
        end
        // The slot right after release belongs to thread 1
        expected_thread = thread_t'(1);

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        run_sequential(START_CYCLES);
        run_jumps(JUMP_CYCLES, NEAR_TOP_PC);
        run_sequential(WRAP_CYCLES);
        run_not_ready(NOT_READY_CYCLES);
        run_sequential(RECOVER_CYCLES);
        run_random(RANDOM_CYCLES);
        stimulus_done = 1'b1;

        // Let the last queued controls come out on issue
        while (control_queue.size() != 0) begin
            @(posedge clock);
        end
        @(negedge clock);

        $display("Checked %0d issues, %0d errors", issue_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // --------------------------------------------------
    // Comparison

    // Outputs are read at the rising edge, before this edge updates them
    always @(posedge clock) begin : compare_issue
        issue_ctrl_t applied;
        pc_t         expected_pc;
        if (reset) begin
            // The very first edge still sees the power-up value
            if (reset_edges != 0) begin
                assert (issue.valid === 1'b0) else begin
                    error_count++;
                    $display("[ERROR] issue.valid expected %h got %h in reset", 1'b0, issue.valid);
                end
            end
            reset_edges++;
            edges_after_reset = 0;
        end else begin
            assert (issue.valid === (edges_after_reset >= 2)) else begin
                error_count++;
                $display("[ERROR] issue.valid expected %h got %h",
                         (edges_after_reset >= 2), issue.valid);
            end
            if (issue.valid === 1'b1) begin
                if (control_queue.size() == 0) begin
                    if (!stimulus_done) begin
                        error_count++;
                        $display("A valid issue appeared with no control in flight");
                    end
                end else begin
                    applied     = control_queue.pop_front();
                    expected_pc = expected_issue_pc(model_current[expected_thread],
                                                    model_previous[expected_thread], applied);
                    assert (issue.thread === expected_thread) else begin
                        error_count++;
                        $display("[ERROR] issue.thread expected %h got %h",
                                 expected_thread, issue.thread);
                    end
                    assert (issue.pc === expected_pc) else begin
                        error_count++;
                        $display("[ERROR] issue.pc expected %h got %h (thread %h)",
                                 expected_pc, issue.pc, expected_thread);
                    end
                    // Write-back, the successor wraps with the PC width
                    model_current[expected_thread]  = pc_t'(expected_pc + 1'b1);
                    model_previous[expected_thread] = expected_pc;
                    if (expected_thread == thread_t'(THREAD_COUNT - 1)) begin
                        expected_thread = thread_t'(0);
                    end else begin
                        expected_thread = thread_t'(expected_thread + 1'b1);
                    end
                    issue_count++;
                end
            end
            edges_after_reset++;
        end
    end

    // --------------------------------------------------
    // Timeout

    initial begin
        cycle_count       = 0;
        reset_edges       = 0;
        edges_after_reset = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not reach its end", cycle_count);
        $display("Checked %0d issues, %0d errors", issue_count, error_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: barrel_pc_top.f
src/barrel_pkg.sv
src/thread_counter.sv
src/thread_pc_memory.sv
src/pc_controller.sv
src/barrel_pc_top.sv
tests/barrel_pc_tb.sv

// File: Bender.yml
# Bender manifest for the barrel-scheduled PC front end

package:
  name: barrel_pc

sources:
  # RTL in compile order, package first
  - files:
      - src/barrel_pkg.sv
      - src/thread_counter.sv
      - src/thread_pc_memory.sv
      - src/pc_controller.sv
      - src/barrel_pc_top.sv

  # Testbench, top module barrel_pc_tb
  - target: test
    files:
      - tests/barrel_pc_tb.sv
